//--- files.f
+incdir+rtl
rtl/axil_demux_pkg.sv
rtl/sel_fifo.sv
rtl/aw_dispatch.sv
rtl/wb_steer.sv
rtl/axil_wr_demux.sv
verif/tb_clk_gen.sv
verif/tb_axil_wr_demux.sv

//--- rtl/aw_dispatch.sv
// Write address dispatch

`include "axil_demux_consts.svh"

module aw_dispatch
  import axil_demux_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // subordinate side AW
  input  logic                       aw_valid_i,
  input  logic [`AXIL_ADDR_W-1:0]    aw_addr_i,
  input  port_sel_t                  aw_sel_i,
  output logic                       aw_ready_o,
  // manager side AW, address broadcast
  output logic [`AXIL_NUM_PORTS-1:0] mst_aw_valid_o,
  output logic [`AXIL_ADDR_W-1:0]    mst_aw_addr_o,
  input  logic [`AXIL_NUM_PORTS-1:0] mst_aw_ready_i,
  // W-order queue head towards the W steering
  output port_sel_t                  w_sel_o,
  output logic                       w_sel_empty_o,
  input  logic                       w_sel_pop_i
);

  logic lock_d;
  logic lock_q;
  logic w_push;
  logic w_full;

  assign mst_aw_addr_o = aw_addr_i;

  // --------------------------------------------------
  // handshake and lock
  // --------------------------------------------------
  // the select is pushed on the first cycle the valid goes out;
  // while the chosen port stalls the lock keeps the valid up
  // without pushing again
  always_comb begin
    lock_d         = lock_q;
    aw_ready_o     = 1'b0;
    mst_aw_valid_o = '0;
    w_push         = 1'b0;
    if (lock_q) begin
      mst_aw_valid_o[aw_sel_i] = 1'b1;
      if (mst_aw_ready_i[aw_sel_i]) begin
        aw_ready_o = 1'b1;
        lock_d     = 1'b0;
      end
    end else if (aw_valid_i && !w_full) begin
      w_push                   = 1'b1;
      mst_aw_valid_o[aw_sel_i] = 1'b1;
      if (mst_aw_ready_i[aw_sel_i]) begin
        aw_ready_o = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // --------------------------------------------------
  // W-order queue
  // --------------------------------------------------
  sel_fifo #(
    .DEPTH    (`AXIL_MAX_TRANS)
  ) u_w_order (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (w_push),
    .data_i   (aw_sel_i),
    .pop_i    (w_sel_pop_i),
    .data_o   (w_sel_o),
    .full_o   (w_full),
    .empty_o  (w_sel_empty_o)
  );

  a_sel_in_range : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_valid_i |-> (int'(aw_sel_i) < `AXIL_NUM_PORTS))
    else $error("aw_sel_i names a port that does not exist");

  // a stalled address stays on the same port until it is taken
  a_locked_valid_held : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (|mst_aw_valid_o && !aw_ready_o) |=> (mst_aw_valid_o == $past(mst_aw_valid_o)))
    else $error("manager AW valid dropped or moved before acceptance");

endmodule

//--- rtl/axil_demux_consts.svh
// AXI4-Lite write demux constants

`ifndef AXIL_DEMUX_CONSTS_SVH
`define AXIL_DEMUX_CONSTS_SVH

// bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// number of manager-side ports
`define AXIL_NUM_PORTS 4

// outstanding selects held by each order queue
`define AXIL_MAX_TRANS 4

`endif

//--- rtl/axil_demux_pkg.sv
// AXI4-Lite write demux types

`include "axil_demux_consts.svh"

package axil_demux_pkg;

  // index of a manager-side port
  typedef logic [$clog2(`AXIL_NUM_PORTS)-1:0] port_sel_t;

  // AXI write response code
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

endpackage

//--- rtl/axil_wr_demux.sv
// AXI4-Lite write path demux

`include "axil_demux_consts.svh"

module axil_wr_demux
  import axil_demux_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // --------------------------------------------------
  // subordinate side
  // --------------------------------------------------
  input  logic                        aw_valid_i,
  input  logic [`AXIL_ADDR_W-1:0]     aw_addr_i,
  input  port_sel_t                   aw_sel_i,
  output logic                        aw_ready_o,
  input  logic                        w_valid_i,
  input  logic [`AXIL_DATA_W-1:0]     w_data_i,
  input  logic [`AXIL_STRB_W-1:0]     w_strb_i,
  output logic                        w_ready_o,
  output logic                        b_valid_o,
  output resp_t                       b_resp_o,
  input  logic                        b_ready_i,
  // --------------------------------------------------
  // manager side, one bit or entry per port
  // --------------------------------------------------
  output logic [`AXIL_NUM_PORTS-1:0]  mst_aw_valid_o,
  output logic [`AXIL_ADDR_W-1:0]     mst_aw_addr_o,
  input  logic [`AXIL_NUM_PORTS-1:0]  mst_aw_ready_i,
  output logic [`AXIL_NUM_PORTS-1:0]  mst_w_valid_o,
  output logic [`AXIL_DATA_W-1:0]     mst_w_data_o,
  output logic [`AXIL_STRB_W-1:0]     mst_w_strb_o,
  input  logic [`AXIL_NUM_PORTS-1:0]  mst_w_ready_i,
  input  logic [`AXIL_NUM_PORTS-1:0]  mst_b_valid_i,
  input  resp_t [`AXIL_NUM_PORTS-1:0] mst_b_resp_i,
  output logic [`AXIL_NUM_PORTS-1:0]  mst_b_ready_o
);

  // W-order queue head, owned by dispatch and popped by steering
  port_sel_t w_sel;
  logic      w_sel_empty;
  logic      w_sel_pop;

  aw_dispatch u_aw_dispatch (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .aw_valid_i     (aw_valid_i),
    .aw_addr_i      (aw_addr_i),
    .aw_sel_i       (aw_sel_i),
    .aw_ready_o     (aw_ready_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .w_sel_o        (w_sel),
    .w_sel_empty_o  (w_sel_empty),
    .w_sel_pop_i    (w_sel_pop)
  );

  wb_steer u_wb_steer (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .w_valid_i     (w_valid_i),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .w_ready_o     (w_ready_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_data_o  (mst_w_data_o),
    .mst_w_strb_o  (mst_w_strb_o),
    .mst_w_ready_i (mst_w_ready_i),
    .w_sel_i       (w_sel),
    .w_sel_empty_i (w_sel_empty),
    .w_sel_pop_o   (w_sel_pop),
    .b_valid_o     (b_valid_o),
    .b_resp_o      (b_resp_o),
    .b_ready_i     (b_ready_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_resp_i  (mst_b_resp_i),
    .mst_b_ready_o (mst_b_ready_o)
  );

endmodule

//--- rtl/sel_fifo.sv
// In-order port select queue

`include "axil_demux_consts.svh"

module sel_fifo
  import axil_demux_pkg::*;
#(
  parameter int unsigned DEPTH = `AXIL_MAX_TRANS
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      push_i,
  input  port_sel_t data_i,
  input  logic      pop_i,
  output port_sel_t data_o,
  output logic      full_o,
  output logic      empty_o
);

  // a single entry still needs a one-bit pointer
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  port_sel_t        mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  // oldest entry, no fall-through from data_i
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // callers gate push and pop with the flags
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> !full_o)
    else $error("select queue pushed while full");

  a_no_underflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> !empty_o)
    else $error("select queue popped while empty");

endmodule

//--- rtl/wb_steer.sv
// W steering and B merging

`include "axil_demux_consts.svh"

module wb_steer
  import axil_demux_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // subordinate side W
  input  logic                                w_valid_i,
  input  logic [`AXIL_DATA_W-1:0]             w_data_i,
  input  logic [`AXIL_STRB_W-1:0]             w_strb_i,
  output logic                                w_ready_o,
  // manager side W, data and strobe broadcast
  output logic [`AXIL_NUM_PORTS-1:0]          mst_w_valid_o,
  output logic [`AXIL_DATA_W-1:0]             mst_w_data_o,
  output logic [`AXIL_STRB_W-1:0]             mst_w_strb_o,
  input  logic [`AXIL_NUM_PORTS-1:0]          mst_w_ready_i,
  // head of the W-order queue
  input  port_sel_t                           w_sel_i,
  input  logic                                w_sel_empty_i,
  output logic                                w_sel_pop_o,
  // subordinate side B
  output logic                                b_valid_o,
  output resp_t                               b_resp_o,
  input  logic                                b_ready_i,
  // manager side B
  input  logic [`AXIL_NUM_PORTS-1:0]          mst_b_valid_i,
  input  resp_t [`AXIL_NUM_PORTS-1:0]         mst_b_resp_i,
  output logic [`AXIL_NUM_PORTS-1:0]          mst_b_ready_o
);

  logic      w_open;
  logic      w_xfer;
  port_sel_t b_sel;
  logic      b_full;
  logic      b_empty;
  logic      b_pop;

  // --------------------------------------------------
  // W channel
  // --------------------------------------------------
  // a beat may leave only when its address is known and
  // there is room to remember where its response comes from
  assign w_open = !w_sel_empty_i && !b_full;

  assign mst_w_data_o = w_data_i;
  assign mst_w_strb_o = w_strb_i;

  for (genvar i = 0; i < `AXIL_NUM_PORTS; i++) begin : g_mst_w
    assign mst_w_valid_o[i] = w_open && w_valid_i && (w_sel_i == port_sel_t'(i));
  end

  assign w_ready_o   = w_open && mst_w_ready_i[w_sel_i];
  assign w_xfer      = w_valid_i && w_ready_o;
  assign w_sel_pop_o = w_xfer;

  // --------------------------------------------------
  // B-order queue
  // --------------------------------------------------
  sel_fifo #(
    .DEPTH    (`AXIL_MAX_TRANS)
  ) u_b_order (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (w_xfer),
    .data_i   (w_sel_i),
    .pop_i    (b_pop),
    .data_o   (b_sel),
    .full_o   (b_full),
    .empty_o  (b_empty)
  );

  // --------------------------------------------------
  // B channel
  // --------------------------------------------------
  // only the port at the head may answer, others wait their turn
  assign b_valid_o = !b_empty && mst_b_valid_i[b_sel];
  assign b_resp_o  = b_empty ? OKAY : mst_b_resp_i[b_sel];

  for (genvar i = 0; i < `AXIL_NUM_PORTS; i++) begin : g_mst_b
    assign mst_b_ready_o[i] = !b_empty && b_ready_i && (b_sel == port_sel_t'(i));
  end

  assign b_pop = b_valid_o && b_ready_i;

  // relies on the manager port holding its response
  a_b_held : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (b_valid_o && !b_ready_i) |=> (b_valid_o && $stable(b_resp_o)))
    else $error("B response dropped or changed before b_ready_i");

endmodule

//--- run.sh
#!/bin/sh
# build and run the AXI4-Lite write demux testbench with Verilator

verilator --binary --timing --assert -f files.f --top-module tb_axil_wr_demux \
  -o tb_axil_wr_demux > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_axil_wr_demux > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

//--- verif/tb_axil_wr_demux.sv
// AXI4-Lite write demux testbench

`include "axil_demux_consts.svh"

module tb_axil_wr_demux
  import axil_demux_pkg::*;
();

  localparam int NP      = `AXIL_NUM_PORTS;
  localparam int STRB_W  = `AXIL_STRB_W;
  localparam int N_RAND  = 24;
  localparam int N_BP    = `AXIL_MAX_TRANS + 2;
  localparam int TIMEOUT = 400;

  logic clk_i, arst_n_i;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic [`AXIL_ADDR_W-1:0] aw_addr_i, mst_aw_addr_o;
  logic [`AXIL_DATA_W-1:0] w_data_i, mst_w_data_o;
  logic [STRB_W-1:0] w_strb_i, mst_w_strb_o;
  port_sel_t aw_sel_i;
  resp_t b_resp_o;
  logic [NP-1:0] mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i;
  logic [NP-1:0] mst_b_valid_i, mst_b_ready_o;
  resp_t [NP-1:0] mst_b_resp_i;

  // port of every issued address, in issue order
  port_sel_t sel_log [64];
  int aw_issued = 0;
  // transfer counts and errors seen by the monitor
  int aw_count = 0, w_count = 0, b_count = 0;
  int err_aw = 0, err_w = 0, err_b = 0;
  int w_acc [NP] = '{default: 0};
  int b_acc [NP] = '{default: 0};
  int passed = 0, failed = 0;

  tb_clk_gen u_clk_gen (
    .clk_o    (clk_i),
    .arst_n_o (arst_n_i)
  );

  axil_wr_demux uut (.*);

  function automatic logic [NP-1:0] onehot(input port_sel_t s);
    return NP'(1) << s;
  endfunction

  function automatic void show_mismatch(input string sig, input logic [63:0] got,
                                        input logic [63:0] exp);
    $display("ERROR at %0t: %s is %0h, expected %0h", $time, sig, got, exp);
  endfunction

  task automatic abort_run(input string why);
    $display("timeout at %0t: %s", $time, why);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic report_test(input int num, input string name, input int errs);
    if (errs == 0) begin
      $display("test %0d %s: ok", num, name);
      passed++;
    end else begin
      $display("test %0d %s: %0d errors", num, name, errs);
      failed++;
    end
  endtask

  // --------------------------------------------------
  // subordinate-side drivers
  // --------------------------------------------------
  // one beat at a time on AW or W, random gaps in between
  task automatic send_beats(input bit is_w, input int n);
    int t;
    for (int i = 0; i < n; i++) begin
      repeat ($urandom_range(2, 0)) begin
        @(posedge clk_i);
        #2;
      end
      if (is_w) begin
        w_data_i  = $urandom;
        w_strb_i  = STRB_W'($urandom);
        w_valid_i = 1'b1;
      end else begin
        aw_addr_i = $urandom;
        aw_sel_i  = port_sel_t'($urandom_range(NP - 1, 0));
        sel_log[aw_issued] = aw_sel_i;
        aw_issued++;
        aw_valid_i = 1'b1;
      end
      t = 0;
      @(negedge clk_i);
      while (!(is_w ? w_ready_o : aw_ready_o)) begin
        t++;
        if (t > TIMEOUT) begin
          abort_run(is_w ? "a W beat was never accepted" : "an address was never accepted");
        end
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #2;
      if (is_w) begin
        w_valid_i = 1'b0;
      end else begin
        aw_valid_i = 1'b0;
      end
    end
  endtask

  task automatic wait_b_count(input int target);
    int t;
    t = 0;
    while (b_count < target) begin
      t++;
      if (t > TIMEOUT) begin
        abort_run("not all B responses came back");
      end
      @(negedge clk_i);
    end
  endtask

  // --------------------------------------------------
  // manager-side port models
  // --------------------------------------------------
  // random readies, one delayed B per accepted W, resp is the port index
  initial begin : responders
    int b_up [NP];
    int gap [NP];
    mst_aw_ready_i = '0;
    mst_w_ready_i  = '0;
    mst_b_valid_i  = '0;
    b_ready_i      = 1'b0;
    for (int p = 0; p < NP; p++) begin
      mst_b_resp_i[p] = resp_t'(p);
      b_up[p] = 0;
      gap[p]  = 0;
    end
    forever begin
      @(posedge clk_i);
      #2;
      mst_aw_ready_i = NP'($urandom);
      mst_w_ready_i  = NP'($urandom);
      b_ready_i      = ($urandom_range(3, 0) != 0);
      for (int p = 0; p < NP; p++) begin
        if (mst_b_valid_i[p] && b_acc[p] == b_up[p]) begin
          mst_b_valid_i[p] = 1'b0;
          gap[p] = $urandom_range(3, 0);
        end else if (!mst_b_valid_i[p] && w_acc[p] > b_up[p]) begin
          if (gap[p] == 0) begin
            mst_b_valid_i[p] = 1'b1;
            b_up[p]++;
          end else begin
            gap[p]--;
          end
        end
      end
    end
  end

  // sampled mid-cycle, a beat seen here transfers on the next rising edge
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (aw_valid_i && aw_ready_o) begin
        if (mst_aw_valid_o !== onehot(aw_sel_i) || mst_aw_addr_o !== aw_addr_i) begin
          show_mismatch("mst_aw_valid_o, mst_aw_addr_o", 64'({mst_aw_valid_o, mst_aw_addr_o}),
                        64'({onehot(aw_sel_i), aw_addr_i}));
          err_aw++;
        end
        if (mst_aw_ready_i[aw_sel_i] !== 1'b1) begin
          $display("at %0t aw_ready_o was high while port %0d was not ready",
                   $time, aw_sel_i);
          err_aw++;
        end
        aw_count++;
      end else begin
        if (mst_aw_valid_o !== '0 && mst_aw_valid_o !== onehot(aw_sel_i)) begin
          show_mismatch("mst_aw_valid_o", 64'(mst_aw_valid_o), 64'(onehot(aw_sel_i)));
          err_aw++;
        end
        if ((mst_aw_valid_o & mst_aw_ready_i) !== '0) begin
          $display("at %0t a port took an address that aw_ready_o did not accept", $time);
          err_aw++;
        end
      end
      if (w_valid_i && w_ready_o) begin
        if (w_count >= aw_issued) begin
          $display("at %0t a W beat went out before its address was issued", $time);
          err_w++;
        end else if (mst_w_valid_o !== onehot(sel_log[w_count])) begin
          show_mismatch("mst_w_valid_o", 64'(mst_w_valid_o), 64'(onehot(sel_log[w_count])));
          err_w++;
        end else if (mst_w_ready_i[sel_log[w_count]] !== 1'b1) begin
          $display("at %0t w_ready_o was high while port %0d was not ready",
                   $time, sel_log[w_count]);
          err_w++;
        end
        if ({mst_w_data_o, mst_w_strb_o} !== {w_data_i, w_strb_i}) begin
          show_mismatch("mst_w_data_o, mst_w_strb_o", 64'({mst_w_data_o, mst_w_strb_o}),
                        64'({w_data_i, w_strb_i}));
          err_w++;
        end
        w_count++;
      end else if ((mst_w_valid_o & mst_w_ready_i) !== '0) begin
        $display("at %0t a port took a W beat that w_ready_o did not accept", $time);
        err_w++;
      end
      if (b_valid_o && b_ready_i) begin
        if (b_count >= w_count) begin
          $display("at %0t a B response came back with no W beat before it", $time);
          err_b++;
        end else begin
          if (b_resp_o !== resp_t'(sel_log[b_count])) begin
            show_mismatch("b_resp_o", 64'(b_resp_o), 64'(sel_log[b_count]));
            err_b++;
          end
          if ((mst_b_valid_i & mst_b_ready_o) !== onehot(sel_log[b_count])) begin
            show_mismatch("mst_b_valid_i & mst_b_ready_o",
                          64'(mst_b_valid_i & mst_b_ready_o), 64'(onehot(sel_log[b_count])));
            err_b++;
          end
        end
        b_count++;
      end else if ((mst_b_valid_i & mst_b_ready_o) !== '0) begin
        $display("at %0t a port gave up a B response that b_valid_o did not pass on", $time);
        err_b++;
      end
      for (int p = 0; p < NP; p++) begin
        if (mst_w_valid_o[p] && mst_w_ready_i[p]) begin
          w_acc[p]++;
        end
        if (mst_b_valid_i[p] && mst_b_ready_o[p]) begin
          b_acc[p]++;
        end
      end
    end
  end

  initial begin : main
    int t;
    int base;
    int prior;
    int rst_errs;
    int bp_errs;
    void'($urandom(48295));
    rst_errs   = 0;
    bp_errs    = 0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_sel_i   = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    t = 0;
    while (arst_n_i !== 1'b1) begin
      t++;
      if (t > 10) begin
        abort_run("reset was never released");
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    if ({mst_aw_valid_o, mst_w_valid_o, b_valid_o} !== '0) begin
      show_mismatch("mst_aw_valid_o, mst_w_valid_o, b_valid_o",
                    64'({mst_aw_valid_o, mst_w_valid_o, b_valid_o}), 64'(0));
      rst_errs++;
    end
    report_test(1, "reset state", rst_errs);

    @(posedge clk_i);
    #2;
    fork
      send_beats(1'b0, N_RAND);
      send_beats(1'b1, N_RAND);
    join
    wait_b_count(N_RAND);
    report_test(2, "address routing", err_aw);
    report_test(3, "W steering", err_w);
    report_test(4, "B order and resp", err_b);

    // W held back until the W-order queue has filled
    prior = err_aw + err_w + err_b;
    base  = aw_count;
    @(posedge clk_i);
    #2;
    fork
      send_beats(1'b0, N_BP);
      begin
        repeat (30) @(negedge clk_i);
        @(posedge clk_i);
        #2;
        if (aw_count - base > `AXIL_MAX_TRANS) begin
          $display("at %0t %0d addresses were taken with no W beat, the queue holds %0d",
                   $time, aw_count - base, `AXIL_MAX_TRANS);
          bp_errs++;
        end
        send_beats(1'b1, N_BP);
      end
    join
    wait_b_count(N_RAND + N_BP);
    report_test(5, "back-pressure", bp_errs + err_aw + err_w + err_b - prior);

    $display("tests passed: %0d, tests failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock and reset

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // period of 40
  initial begin
    clk_o = 1'b0;
    forever begin
      #20;
      clk_o = ~clk_o;
    end
  end

  // reset held over the first three rising edges, released just after the third
  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule
